// File: rtl/nocPkg.sv
// Shared flit and port definitions for the 4x4 mesh router
// Address is 4 bits, x in the low half and y in the high half
// A flit is 32 bits. Single-flit packets are not supported
`default_nettype none

package nocPkg;

  // Router port count, fixed for a 2D mesh plus local
  localparam int NumPorts = 5;

  // Mesh address, bits 1:0 are x and bits 3:2 are y
  typedef logic [3:0] addrT;

  // Flit payload carried beside kind and destination
  typedef logic [25:0] flitDataT;

  // Flit kinds within one wormhole packet
  typedef enum logic [1:0] {
    FlitHeader  = 2'd0,
    FlitPayload = 2'd1,
    FlitTail    = 2'd2
  } flitKindT;

  // One flit, as carried by FIFOs, crossbar lanes and ports
  typedef struct packed {
    flitKindT kind;
    addrT     dst;
    flitDataT data;
  } flitT;

  // Port indices, also the bit order of a route vector
  typedef enum logic [2:0] {
    PortNorth = 3'd0,
    PortEast  = 3'd1,
    PortWest  = 3'd2,
    PortSouth = 3'd3,
    PortLocal = 3'd4
  } portT;

endpackage

`default_nettype wire

// File: rtl/routePkg.sv
// LBDR configuration types, minimal support only
// Routing bits go ne, nw, en, es, wn, ws, se, sw from bit 0 up
// Connectivity bits go n, e, w, s from bit 0 up
`default_nettype none

package routePkg;

  // Routing bits, two per output port
  typedef logic [7:0] rxyT;

  // Connectivity bits, one per mesh output
  typedef logic [3:0] cxT;

  // One-hot output port vector, indexed by nocPkg::portT, zero when unroutable
  typedef logic [4:0] routeT;

  // Bit positions inside rxyT
  localparam int RNe = 0;
  localparam int RNw = 1;
  localparam int REn = 2;
  localparam int REs = 3;
  localparam int RWn = 4;
  localparam int RWs = 5;
  localparam int RSe = 6;
  localparam int RSw = 7;

  // Bit positions inside cxT
  localparam int CN = 0;
  localparam int CE = 1;
  localparam int CW = 2;
  localparam int CS = 3;

  // Sampled while rst is high, shared by all route units
  typedef struct packed {
    rxyT          rxy;
    cxT           cx;
    nocPkg::addrT curAddr;
  } routeCfgT;

endpackage

`default_nettype wire

// File: rtl/inputFifo.sv
// Per-input flit FIFO, FifoDepth must be a power of two, 2 or more
// Head flit is visible the cycle after the write
// Writes while full are dropped and flagged as an upstream error
`timescale 1ns/1ps
`default_nettype none

module inputFifo #(
  parameter int FifoDepth = 4
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  nocPkg::flitT wrFlit,
  input  wire logic  wrEn,
  input  wire logic  pop,
  output nocPkg::flitT headFlit,
  output logic       empty,
  output logic       full
);

  import nocPkg::*;

  localparam int PtrW = $clog2(FifoDepth);

  // Flit storage
  flitT mem [FifoDepth];

  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  // One extra bit so a full FIFO is distinguishable from empty
  logic [PtrW:0]   count;

  logic doWrite;
  logic doRead;

  assign empty = (count == '0);
  assign full  = (count == (PtrW + 1)'(FifoDepth));

  // Guarded transfers
  assign doWrite = wrEn && !full;
  assign doRead  = pop && !empty;

  assign headFlit = mem[rdPtr];

  // Storage write, no reset needed
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= wrFlit;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Upstream must honour full
  noWriteWhenFull: assert property (@(posedge clk) disable iff (rst) !(wrEn && full))
    else $error("write to a full input FIFO");

  // Allocator must only pop a flit that is there
  noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("pop from an empty input FIFO");

endmodule

`default_nettype wire

// File: rtl/lbdrRoute.sv
// LBDR route unit with minimal support and no deroutes or forks
// Config is captured only while rst is high
// Route is taken from the header and held until the tail is popped
`timescale 1ns/1ps
`default_nettype none

module lbdrRoute (
  input  wire logic         clk,
  input  wire logic         rst,
  input  routePkg::routeCfgT cfg,
  input  nocPkg::flitT      headFlit,
  input  wire logic         empty,
  input  wire logic         tailDone,
  output routePkg::routeT   route,
  output logic              routeValid,
  output logic              drop,
  output logic              routeError
);

  import nocPkg::*;
  import routePkg::*;

  typedef enum logic [1:0] {
    Idle,
    Routed,
    Dropping
  } stateT;

  stateT    state;
  routeCfgT cfgQ;
  routeT    routeQ;
  routeT    nextRoute;
  logic     errQ;
  logic     headerAtHead;

  // Coordinates of this router and the packet destination
  logic [1:0] xCur;
  logic [1:0] yCur;
  logic [1:0] xDst;
  logic [1:0] yDst;

  // Direction comparators
  logic goN;
  logic goE;
  logic goW;
  logic goS;

  // Configuration capture during reset
  always_ff @(posedge clk) begin
    if (rst) begin
      cfgQ <= cfg;
    end
  end

  assign xCur = cfgQ.curAddr[1:0];
  assign yCur = cfgQ.curAddr[3:2];
  assign xDst = headFlit.dst[1:0];
  assign yDst = headFlit.dst[3:2];

  // Smaller y is further north
  assign goN = (yDst < yCur);
  assign goS = (yDst > yCur);
  assign goE = (xDst > xCur);
  assign goW = (xDst < xCur);

  // LBDR equations where straight lines need only Cx
  // and quadrants need the matching routing bit too
  always_comb begin
    nextRoute = '0;
    nextRoute[PortNorth] = ((goN && !goE && !goW) ||
                            (goN && goE && cfgQ.rxy[RNe]) ||
                            (goN && goW && cfgQ.rxy[RNw])) && cfgQ.cx[CN];
    // East is ANDed with its connectivity bit like the others
    nextRoute[PortEast]  = ((goE && !goN && !goS) ||
                            (goE && goN && cfgQ.rxy[REn]) ||
                            (goE && goS && cfgQ.rxy[REs])) && cfgQ.cx[CE];
    nextRoute[PortWest]  = ((goW && !goN && !goS) ||
                            (goW && goN && cfgQ.rxy[RWn]) ||
                            (goW && goS && cfgQ.rxy[RWs])) && cfgQ.cx[CW];
    nextRoute[PortSouth] = ((goS && !goE && !goW) ||
                            (goS && goE && cfgQ.rxy[RSe]) ||
                            (goS && goW && cfgQ.rxy[RSw])) && cfgQ.cx[CS];
    // Own address
    nextRoute[PortLocal] = !goN && !goE && !goW && !goS;
  end

  assign headerAtHead = !empty && (headFlit.kind == FlitHeader);

  // Per-packet route FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= Idle;
      routeQ <= '0;
      errQ   <= 1'b0;
    end else begin
      errQ <= 1'b0;
      case (state)
        Idle: begin
          if (headerAtHead) begin
            routeQ <= nextRoute;
            if (nextRoute == '0) begin
              // Unroutable so the whole packet is flushed
              state <= Dropping;
              errQ  <= 1'b1;
            end else begin
              state <= Routed;
            end
          end
        end
        Routed, Dropping: begin
          // Release once the tail has left the FIFO
          if (tailDone) begin
            state  <= Idle;
            routeQ <= '0;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  assign route      = routeQ;
  assign routeValid = (state == Routed);
  assign drop       = (state == Dropping);
  assign routeError = errQ;

  // A held route names exactly one port
  routeOneHot: assert property (@(posedge clk) disable iff (rst)
    routeValid |-> $onehot(route))
    else $error("held route is not one-hot");

endmodule

`default_nettype wire

// File: rtl/switchAllocator.sv
// Per-output round-robin switch allocator with wormhole locks
// An output stays locked from header grant until its owner pops the tail
// Outputs never stall, so a granted head flit always leaves
`timescale 1ns/1ps
`default_nettype none

module switchAllocator (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  routePkg::routeT                  route [nocPkg::NumPorts],
  input  wire logic [nocPkg::NumPorts-1:0] routeValid,
  input  wire logic [nocPkg::NumPorts-1:0] drop,
  input  wire logic [nocPkg::NumPorts-1:0] empty,
  input  nocPkg::flitKindT                 headKind [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0]      pop,
  output logic [nocPkg::NumPorts-1:0]      tailDone,
  output nocPkg::portT                     xbarSel [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0]      xbarEn
);

  import nocPkg::*;
  import routePkg::*;

  // Lock state and last winner per output
  logic [NumPorts-1:0] locked;
  portT                owner [NumPorts];
  portT                rrPtr [NumPorts];

  // req[i][o], input i wants output o this cycle
  routeT               req [NumPorts];
  portT                grantIdx [NumPorts];
  logic [NumPorts-1:0] grantValid;

  // Outputs granting each input, for the exclusivity check
  logic [2:0]          grantCount [NumPorts];
  logic [NumPorts-1:0] multiGrant;

  // Requests only from routed inputs with a flit waiting
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      req[i] = (routeValid[i] && !empty[i]) ? route[i] : '0;
    end
  end

  // Grant selection
  always_comb begin
    int cand;
    cand = 0;
    for (int o = 0; o < NumPorts; o++) begin
      grantIdx[o]   = owner[o];
      grantValid[o] = 1'b0;
      if (locked[o]) begin
        // Owner keeps the output, moves whenever it has a flit
        grantValid[o] = !empty[owner[o]];
      end else begin
        // Search starts just after the last winner
        for (int k = 1; k <= NumPorts; k++) begin
          cand = (int'(rrPtr[o]) + k) % NumPorts;
          if (!grantValid[o] && req[cand][o]) begin
            grantValid[o] = 1'b1;
            grantIdx[o]   = portT'(cand);
          end
        end
      end
    end
  end

  // Pops come from grants or from a packet being flushed
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      pop[i]        = drop[i] && !empty[i];
      grantCount[i] = '0;
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (grantValid[o]) begin
        pop[grantIdx[o]]        = 1'b1;
        grantCount[grantIdx[o]] = grantCount[grantIdx[o]] + 3'd1;
      end
    end
    for (int i = 0; i < NumPorts; i++) begin
      tailDone[i]   = pop[i] && (headKind[i] == FlitTail);
      multiGrant[i] = (grantCount[i] > 3'd1);
    end
  end

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      xbarSel[o] = grantIdx[o];
    end
  end

  assign xbarEn = grantValid;

  // Lock and pointer update
  always_ff @(posedge clk) begin
    if (rst) begin
      locked <= '0;
      for (int o = 0; o < NumPorts; o++) begin
        owner[o] <= PortLocal;
        // So the first search starts at north
        rrPtr[o] <= PortLocal;
      end
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (grantValid[o]) begin
          if (headKind[grantIdx[o]] == FlitTail) begin
            locked[o] <= 1'b0;
          end else begin
            locked[o] <= 1'b1;
            owner[o]  <= grantIdx[o];
          end
          if (!locked[o]) begin
            rrPtr[o] <= grantIdx[o];
          end
        end
      end
    end
  end

  // Relies on one-hot routes from the route units and on lock bookkeeping
  singleGrant: assert property (@(posedge clk) disable iff (rst) multiGrant == '0)
    else $error("input granted by more than one output");

endmodule

`default_nettype wire

// File: rtl/crossbar.sv
// Registered 5x5 flit crossbar, one cycle from select to output
// outValid is a one-cycle strobe per forwarded flit
`timescale 1ns/1ps
`default_nettype none

module crossbar (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  nocPkg::flitT                     inFlit [nocPkg::NumPorts],
  input  nocPkg::portT                     sel [nocPkg::NumPorts],
  input  wire logic [nocPkg::NumPorts-1:0] en,
  output nocPkg::flitT                     outFlit [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0]      outValid
);

  import nocPkg::*;

  // Output data lanes, loaded only on a grant
  always_ff @(posedge clk) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (en[o]) begin
        outFlit[o] <= inFlit[sel[o]];
      end
    end
  end

  // Strobe follows the enable by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= '0;
    end else begin
      outValid <= en;
    end
  end

endmodule

`default_nettype wire

// File: rtl/router.sv
// Five-port wormhole router for a 4x4 mesh with LBDR routing
// Outputs always accept, upstream must hold off while inFull is high
// cfg is sampled only while rst is high
`timescale 1ns/1ps
`default_nettype none

module router #(
  parameter int FifoDepth = 4
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  routePkg::routeCfgT               cfg,
  input  nocPkg::flitT                     inFlit [nocPkg::NumPorts],
  input  wire logic [nocPkg::NumPorts-1:0] inValid,
  output logic [nocPkg::NumPorts-1:0]      inFull,
  output nocPkg::flitT                     outFlit [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0]      outValid,
  output logic [nocPkg::NumPorts-1:0]      routeError
);

  import nocPkg::*;
  import routePkg::*;

  // FIFO heads
  flitT                headFlit [NumPorts];
  flitKindT            headKind [NumPorts];
  logic [NumPorts-1:0] empty;

  // Route unit outputs
  routeT               route [NumPorts];
  logic [NumPorts-1:0] routeValid;
  logic [NumPorts-1:0] drop;

  // Allocator outputs
  logic [NumPorts-1:0] pop;
  logic [NumPorts-1:0] tailDone;
  portT                xbarSel [NumPorts];
  logic [NumPorts-1:0] xbarEn;

  for (genvar i = 0; i < NumPorts; i++) begin : gInput
    inputFifo #(
      .FifoDepth (FifoDepth)
    ) fifo_i (
      .clk      (clk),
      .rst      (rst),
      .wrFlit   (inFlit[i]),
      .wrEn     (inValid[i]),
      .pop      (pop[i]),
      .headFlit (headFlit[i]),
      .empty    (empty[i]),
      .full     (inFull[i])
    );

    // Kind of the head flit, for tail detection in the allocator
    assign headKind[i] = headFlit[i].kind;

    lbdrRoute route_i (
      .clk        (clk),
      .rst        (rst),
      .cfg        (cfg),
      .headFlit   (headFlit[i]),
      .empty      (empty[i]),
      .tailDone   (tailDone[i]),
      .route      (route[i]),
      .routeValid (routeValid[i]),
      .drop       (drop[i]),
      .routeError (routeError[i])
    );
  end

  switchAllocator alloc_i (
    .clk        (clk),
    .rst        (rst),
    .route      (route),
    .routeValid (routeValid),
    .drop       (drop),
    .empty      (empty),
    .headKind   (headKind),
    .pop        (pop),
    .tailDone   (tailDone),
    .xbarSel    (xbarSel),
    .xbarEn     (xbarEn)
  );

  crossbar xbar_i (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (headFlit),
    .sel      (xbarSel),
    .en       (xbarEn),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

// File: testbench/routerTb.sv
// Directed testbench for the five-port LBDR router with FifoDepth fixed at 4
// Output flits are checked against a route model and per-input queues
// Inputs change on the falling edge and outputs are sampled there too
`timescale 1ns/1ps
`default_nettype none

module routerTb;

  import nocPkg::*;
  import routePkg::*;

  localparam int FifoDepth = 4;
  localparam int ClkPeriod = 4;
  localparam int WaitLimit = 200;

  // XY routing at address 5 with all links up
  localparam routeCfgT CfgXy      = {8'h3C, 4'hF, 4'h5};
  // YX routing at address 10
  localparam routeCfgT CfgYx      = {8'hC3, 4'hF, 4'hA};
  // XY routing at address 5 with the north link cut
  localparam routeCfgT CfgNoNorth = {8'h3C, 4'hE, 4'h5};

  logic                clk = 1'b0;
  logic                rst;
  routeCfgT            cfg;
  flitT                inFlit [NumPorts];
  logic [NumPorts-1:0] inValid;
  logic [NumPorts-1:0] inFull;
  flitT                outFlit [NumPorts];
  logic [NumPorts-1:0] outValid;
  logic [NumPorts-1:0] routeError;

  // Expected flits per input in send order
  flitT                expQ [NumPorts][$];
  // Input streaming on each output or -1 when the output is free
  int                  laneSrc [NumPorts];
  time                 sentTime [NumPorts];
  time                 arrTime [NumPorts];
  int                  errCnt [NumPorts];
  logic [NumPorts-1:0] errAllowed;
  // Flits written before inFull was first seen
  int                  firstFull [NumPorts];
  logic [31:0]         lcgState = 32'hdbc6;

  always #(ClkPeriod / 2) clk = ~clk;

  router #(
    .FifoDepth (FifoDepth)
  ) router_i (
    .clk        (clk),
    .rst        (rst),
    .cfg        (cfg),
    .inFlit     (inFlit),
    .inValid    (inValid),
    .inFull     (inFull),
    .outFlit    (outFlit),
    .outValid   (outValid),
    .routeError (routeError)
  );

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Reference LBDR rule that returns -1 when no port is allowed
  function automatic int expectedPort(input routeCfgT c, input addrT dst);
    int dx;
    int dy;
    int port;
    dx = int'(dst[1:0]) - int'(c.curAddr[1:0]);
    dy = int'(dst[3:2]) - int'(c.curAddr[3:2]);
    port = -1;
    if (dx == 0 && dy == 0) begin
      port = 4;
    end else if (dx == 0) begin
      // Straight lines need the link only
      if (dy < 0 && c.cx[0]) begin
        port = 0;
      end else if (dy > 0 && c.cx[3]) begin
        port = 3;
      end
    end else if (dy == 0) begin
      if (dx > 0 && c.cx[1]) begin
        port = 1;
      end else if (dx < 0 && c.cx[2]) begin
        port = 2;
      end
    end else if (dy < 0 && dx > 0) begin
      // Northeast where ne picks north and en picks east
      if (c.rxy[0] && c.cx[0]) begin
        port = 0;
      end else if (c.rxy[2] && c.cx[1]) begin
        port = 1;
      end
    end else if (dy < 0) begin
      // Northwest by nw or wn
      if (c.rxy[1] && c.cx[0]) begin
        port = 0;
      end else if (c.rxy[4] && c.cx[2]) begin
        port = 2;
      end
    end else if (dx > 0) begin
      // Southeast by se or es
      if (c.rxy[6] && c.cx[3]) begin
        port = 3;
      end else if (c.rxy[3] && c.cx[1]) begin
        port = 1;
      end
    end else begin
      // Southwest by sw or ws
      if (c.rxy[7] && c.cx[3]) begin
        port = 3;
      end else if (c.rxy[5] && c.cx[2]) begin
        port = 2;
      end
    end
    return port;
  endfunction

  task automatic applyReset(input routeCfgT newCfg);
    @(negedge clk);
    rst = 1'b1;
    cfg = newCfg;
    inValid = '0;
    errAllowed = '0;
    for (int i = 0; i < NumPorts; i++) begin
      expQ[i].delete();
      laneSrc[i] = -1;
      errCnt[i] = 0;
      firstFull[i] = -1;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    checkEq("outValid after reset", 32'(outValid), 32'd0);
    checkEq("routeError after reset", 32'(routeError), 32'd0);
    checkEq("inFull after reset", 32'(inFull), 32'd0);
  endtask

  // Called on a falling edge and returns on a falling edge
  task automatic sendPacket(input int port, input addrT dst, input int len, input bit routable);
    flitT        f;
    logic [31:0] r;
    int          stall;
    for (int k = 0; k < len; k++) begin
      r = nextRand();
      f.dst = dst;
      f.data = r[31:6];
      if (k == 0) begin
        f.kind = FlitHeader;
      end else if (k == len - 1) begin
        f.kind = FlitTail;
      end else begin
        f.kind = FlitPayload;
      end
      stall = 0;
      // Hold off while the FIFO is full
      while (inFull[port]) begin
        if (firstFull[port] < 0) begin
          firstFull[port] = k;
        end
        inValid[port] = 1'b0;
        @(negedge clk);
        stall++;
        if (stall > WaitLimit) begin
          stopOnError($sformatf("error at %0t: input %0d stayed full", $time, port));
        end
      end
      inFlit[port] = f;
      inValid[port] = 1'b1;
      if (k == 0) begin
        sentTime[port] = $time;
      end
      if (routable) begin
        expQ[port].push_back(f);
      end
      @(negedge clk);
    end
    inValid[port] = 1'b0;
  endtask

  task automatic waitDrain();
    int cycles;
    bit busy;
    cycles = 0;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int i = 0; i < NumPorts; i++) begin
        if (expQ[i].size() != 0 || laneSrc[i] >= 0) begin
          busy = 1'b1;
        end
      end
      cycles++;
      if (cycles > WaitLimit) begin
        stopOnError($sformatf("error at %0t: expected flits never arrived", $time));
      end
    end
  endtask

  task automatic waitRouteError(input int port);
    int cycles;
    cycles = 0;
    while (errCnt[port] == 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > WaitLimit) begin
        stopOnError($sformatf("error at %0t: no routeError on input %0d", $time, port));
      end
    end
  endtask

  // Output checker where a free output must start with a pending header
  always @(negedge clk) begin : outputMonitor
    flitT f;
    int   src;
    if (!rst) begin
      for (int i = 0; i < NumPorts; i++) begin
        if (routeError[i]) begin
          if (!errAllowed[i]) begin
            stopOnError($sformatf("error at %0t: unexpected routeError on input %0d", $time, i));
          end
          errCnt[i]++;
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (outValid[o]) begin
          f = outFlit[o];
          if (laneSrc[o] < 0) begin
            src = -1;
            for (int i = 0; i < NumPorts; i++) begin
              if (src < 0 && f.kind == FlitHeader && expQ[i].size() > 0 && expQ[i][0] == f) begin
                src = i;
              end
            end
            if (src < 0) begin
              stopOnError($sformatf("error at %0t: flit %h on output %0d was not expected",
                                    $time, f, o));
            end
            checkEq($sformatf("output port of dst %0d", f.dst), o, expectedPort(cfg, f.dst));
            arrTime[o] = $time;
            laneSrc[o] = src;
          end
          checkEq($sformatf("outFlit[%0d]", o), f, expQ[laneSrc[o]][0]);
          void'(expQ[laneSrc[o]].pop_front());
          if (f.kind == FlitTail) begin
            laneSrc[o] = -1;
          end
        end
      end
    end
  end

  // Four straight lines and the own address from the local input
  task automatic straightRouting();
    addrT dsts [5];
    int   ports [5];
    dsts = '{4'd1, 4'd6, 4'd4, 4'd9, 4'd5};
    ports = '{0, 1, 2, 3, 4};
    for (int t = 0; t < 5; t++) begin
      checkEq("model port", expectedPort(cfg, dsts[t]), ports[t]);
      sendPacket(int'(PortLocal), dsts[t], 3, 1'b1);
      waitDrain();
      checkEq("header latency", 32'(arrTime[ports[t]] - sentTime[int'(PortLocal)]),
              32'(3 * ClkPeriod));
    end
  endtask

  // YX routing at address 10 sends every diagonal north or south
  task automatic quadrantChoice();
    addrT dsts [4];
    int   ports [4];
    dsts = '{4'd0, 4'd3, 4'd12, 4'd15};
    ports = '{0, 0, 3, 3};
    for (int t = 0; t < 4; t++) begin
      checkEq("model port", expectedPort(cfg, dsts[t]), ports[t]);
      sendPacket(t, dsts[t], 4, 1'b1);
      waitDrain();
    end
  endtask

  // North link is cut so a packet to address 1 is dropped
  task automatic connectivityCut();
    errAllowed[int'(PortWest)] = 1'b1;
    checkEq("model port of dst 1", expectedPort(cfg, 4'd1), -1);
    sendPacket(int'(PortWest), 4'd1, 4, 1'b0);
    waitRouteError(int'(PortWest));
    // Next packet on the same input must route normally
    sendPacket(int'(PortWest), 4'd6, 3, 1'b1);
    waitDrain();
    checkEq("routeError count", errCnt[int'(PortWest)], 1);
    errAllowed = '0;
  endtask

  // North and south inputs race for the east output
  task automatic contention();
    fork
      sendPacket(int'(PortNorth), 4'd6, 5, 1'b1);
      sendPacket(int'(PortSouth), 4'd6, 5, 1'b1);
    join
    waitDrain();
  endtask

  // West fills up behind a long east packet to the local output
  task automatic inputFull();
    fork
      sendPacket(int'(PortEast), 4'd5, 12, 1'b1);
      begin
        repeat (2) @(negedge clk);
        sendPacket(int'(PortWest), 4'd5, 8, 1'b1);
      end
    join
    waitDrain();
    checkEq("flits stored before inFull", firstFull[int'(PortWest)], FifoDepth);
  endtask

  initial begin
    rst = 1'b1;
    cfg = CfgXy;
    inValid = '0;
    errAllowed = '0;
    for (int i = 0; i < NumPorts; i++) begin
      inFlit[i] = '0;
      laneSrc[i] = -1;
      errCnt[i] = 0;
      firstFull[i] = -1;
    end
    applyReset(CfgXy);
    straightRouting();
    applyReset(CfgYx);
    quadrantChoice();
    applyReset(CfgNoNorth);
    connectivityCut();
    contention();
    inputFull();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
rtl/nocPkg.sv
rtl/routePkg.sv
rtl/inputFifo.sv
rtl/lbdrRoute.sv
rtl/switchAllocator.sv
rtl/crossbar.sv
rtl/router.sv
testbench/routerTb.sv

// File: run.sh
#!/bin/sh
# Build the router testbench with Verilator, run it, and judge the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module routerTb \
  -o routerSim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/routerSim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
